// File: files.f
hdl/codec_cfg_pkg.sv
hdl/cmd_link_if.sv
hdl/init_sequencer.sv
hdl/host_write_queue.sv
hdl/cmd_arbiter.sv
hdl/i2c_write_engine.sv
hdl/codec_cfg_top.sv
bench/codec_slave_model.sv
bench/codec_cfg_tb.sv

// File: Bender.yml
package:
  name: codec_cfg

sources:
  - files:
      - hdl/codec_cfg_pkg.sv
      - hdl/cmd_link_if.sv
      - hdl/init_sequencer.sv
      - hdl/host_write_queue.sv
      - hdl/cmd_arbiter.sv
      - hdl/i2c_write_engine.sv
      - hdl/codec_cfg_top.sv
  - target: test
    files:
      - bench/codec_slave_model.sv
      - bench/codec_cfg_tb.sv

// File: bench/codec_cfg_tb.sv
`timescale 1ns/10ps

module codec_cfg_tb;

    localparam int ROWS        = 20;
    localparam int INIT_ROWS   = 7;
    localparam int BURST_FIRST = 12;    // rows from here on are issued back to back
    localparam int DROP_TRIES  = 3;
    localparam int TIMEOUT_CYC = 4 * ROWS * 80;

    logic        clk;
    logic        rst_n;
    logic        start;
    logic        wr_valid;
    logic [6:0]  wr_addr;
    logic [8:0]  wr_data;
    logic        ack;
    logic        wr_ready;
    logic        init_done;
    logic        nack_err;
    logic        sclk;
    logic        sdat;
    logic        oen;
    logic        refuse_set;
    logic [1:0]  refuse_cnt;
    logic        bus_start;
    logic        frame_valid;
    logic [23:0] frame;

    string       row_name   [ROWS];
    logic        row_issue  [ROWS];
    logic [6:0]  row_addr   [ROWS];
    logic [8:0]  row_data   [ROWS];
    logic [1:0]  row_refuse [ROWS];
    logic [23:0] row_exp    [ROWS];
    int          n_rows;

    logic [23:0] frame_log [ROWS + 8];
    int          log_cnt;
    int          start_cnt;
    int          nack_cnt;
    int          mismatches;
    int          failures;
    logic        ready_low_seen;
    logic [31:0] lfsr;

    codec_cfg_top i_dut (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_start     (start),
        .i_wr_valid  (wr_valid),
        .i_wr_addr   (wr_addr),
        .i_wr_data   (wr_data),
        .i_ack       (ack),
        .o_wr_ready  (wr_ready),
        .o_init_done (init_done),
        .o_nack_err  (nack_err),
        .o_sclk      (sclk),
        .o_sdat      (sdat),
        .o_oen       (oen)
    );

    codec_slave_model u_codec (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_sclk        (sclk),
        .i_sdat        (sdat),
        .i_oen         (oen),
        .i_refuse_set  (refuse_set),
        .i_refuse_cnt  (refuse_cnt),
        .o_ack         (ack),
        .o_start       (bus_start),
        .o_frame_valid (frame_valid),
        .o_frame       (frame)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        if (frame_valid) begin
            frame_log[log_cnt] <= frame;
            log_cnt            <= log_cnt + 1;
        end
        if (bus_start) begin
            start_cnt <= start_cnt + 1;
        end
        if (nack_err) begin
            nack_cnt <= nack_cnt + 1;   // high cycles so a long pulse shows
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = (v << 1) | int'(lfsr[0]);
        end
    endtask

    // device byte, then address and data bit 8, then data bits 7 to 0
    function automatic logic [23:0] host_frame(input logic [6:0] addr, input logic [8:0] data);
        return {8'h34, {addr, data[8]}, data[7:0]};
    endfunction

    task automatic add_row(input string name, input logic issue, input logic [6:0] addr,
                           input logic [8:0] data, input logic [1:0] refuse,
                           input logic [23:0] exp_frame);
        row_name[n_rows]   = name;
        row_issue[n_rows]  = issue;
        row_addr[n_rows]   = addr;
        row_data[n_rows]   = data;
        row_refuse[n_rows] = refuse;
        row_exp[n_rows]    = exp_frame;
        n_rows++;
    endtask

    task automatic build_table();
        int         d;
        logic [6:0] a;
        n_rows = 0;
        add_row("init_reset",    1'b0, '0, '0, 2'd0, 24'h341E00);
        add_row("init_line_vol", 1'b0, '0, '0, 2'd0, 24'h340117);
        add_row("init_hp_vol",   1'b0, '0, '0, 2'd0, 24'h340579);
        add_row("init_analog",   1'b0, '0, '0, 2'd0, 24'h340815);
        add_row("init_digital",  1'b0, '0, '0, 2'd0, 24'h340A00);
        add_row("init_power",    1'b0, '0, '0, 2'd0, 24'h340C00);
        add_row("init_active",   1'b0, '0, '0, 2'd0, 24'h341201);
        add_row("vol_left",   1'b1, 7'h02, 9'h079, 2'd0, host_frame(7'h02, 9'h079));
        add_row("vol_right",  1'b1, 7'h03, 9'h179, 2'd1, host_frame(7'h03, 9'h179));
        add_row("dac_mute",   1'b1, 7'h05, 9'h008, 2'd2, host_frame(7'h05, 9'h008));
        add_row("drop",       1'b1, 7'h04, 9'h012, 2'(DROP_TRIES), host_frame(7'h04, 9'h012));
        add_row("after_drop", 1'b1, 7'h06, 9'h100, 2'd0, host_frame(7'h06, 9'h100));
        for (int k = 0; k < 8; k++) begin
            take_bits(9, d);
            a = 7'h20 + 7'(k);
            add_row($sformatf("burst_%0d", k), 1'b1, a, d[8:0], 2'd0, host_frame(a, d[8:0]));
        end
    endtask

    task automatic compare(input string test, input string what,
                           input logic [31:0] exp_val, input logic [31:0] act_val);
        assert (act_val === exp_val) else begin
            $display("Mismatch %s %s: expected %0h, actual %0h", test, what, exp_val, act_val);
            mismatches++;
        end
    endtask

    task automatic issue_writes();
        int gap;
        while (log_cnt == 0) @(posedge clk);   // first frame out while init still runs
        for (int r = 0; r < n_rows; r++) begin
            if (row_issue[r]) begin
                gap = 0;
                if (r < BURST_FIRST) begin
                    take_bits(2, gap);
                end
                if (gap != 0) begin
                    wr_valid <= 1'b0;
                    repeat (gap) @(posedge clk);
                end
                wr_valid <= 1'b1;
                wr_addr  <= row_addr[r];
                wr_data  <= row_data[r];
                @(posedge clk);
                while (!wr_ready) begin
                    if (r >= BURST_FIRST) begin
                        ready_low_seen = 1'b1;
                    end
                    @(posedge clk);
                end
            end
        end
        wr_valid <= 1'b0;
    endtask

    task automatic check_rows();
        int start_base;
        int nack_base;
        int next_log;
        int exp_starts;
        next_log = 0;
        for (int r = 0; r < n_rows; r++) begin
            refuse_cnt <= row_refuse[r];
            refuse_set <= 1'b1;
            @(posedge clk);
            refuse_set <= 1'b0;
            start_base = start_cnt;
            nack_base  = nack_cnt;
            while ((log_cnt == next_log) && (nack_cnt == nack_base)) @(posedge clk);
            if (row_refuse[r] == DROP_TRIES) begin
                exp_starts = DROP_TRIES;   // every attempt refused
                assert ((log_cnt == next_log) && (nack_cnt == nack_base + 1)) else begin
                    $display("Error %s: refused frame was logged instead of dropped", row_name[r]);
                    failures++;
                end
            end else begin
                exp_starts = row_refuse[r] + 1;
                assert ((log_cnt == next_log + 1) && (nack_cnt == nack_base)) else begin
                    $display("Error %s: frame was dropped with o_nack_err", row_name[r]);
                    failures++;
                end
                compare(row_name[r], "frame", row_exp[r], frame_log[next_log]);
                next_log++;
            end
            compare(row_name[r], "start conditions", exp_starts, start_cnt - start_base);
            compare(row_name[r], "o_init_done", (r >= INIT_ROWS - 1), init_done);
        end
    endtask

    task automatic finish_run();
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if ((mismatches == 0) && (failures == 0)) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    initial begin
        repeat (TIMEOUT_CYC) @(posedge clk);
        $display("Timeout: no result after %0d clock cycles", TIMEOUT_CYC);
        failures++;
        finish_run();
    end

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        start          = 1'b0;
        wr_valid       = 1'b0;
        wr_addr        = '0;
        wr_data        = '0;
        refuse_set     = 1'b0;
        refuse_cnt     = '0;
        ready_low_seen = 1'b0;
        lfsr           = 32'h3b3fef57;
        build_table();
        repeat (3) @(posedge clk);
        compare("reset", "o_sclk", 1, sclk);
        compare("reset", "o_sdat", 1, sdat);
        compare("reset", "o_oen", 1, oen);
        compare("reset", "o_init_done", 0, init_done);
        compare("reset", "o_nack_err", 0, nack_err);
        compare("reset", "o_wr_ready", 0, wr_ready);
        rst_n <= 1'b1;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        fork
            issue_writes();
            check_rows();
        join
        assert (ready_low_seen) else begin
            $display("Error burst: o_wr_ready never fell during back to back writes");
            failures++;
        end
        compare("summary", "logged frames", ROWS - 1, log_cnt);
        compare("summary", "o_nack_err cycles", 1, nack_cnt);
        finish_run();
    end

endmodule

// File: bench/codec_slave_model.sv
`timescale 1ns/10ps

module codec_slave_model (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_sclk,
    input  logic        i_sdat,
    input  logic        i_oen,
    input  logic        i_refuse_set,
    input  logic [1:0]  i_refuse_cnt,
    output logic        o_ack,
    output logic        o_start,
    output logic        o_frame_valid,
    output logic [23:0] o_frame
);

    logic        sclk_q;
    logic        sdat_q;
    logic [4:0]  nbits;
    logic [23:0] shift;
    logic [1:0]  refuse_left;
    logic        ack_q = 1'b0;

    assign o_ack = ack_q;   // high means refused

    always @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sclk_q        <= 1'b1;
            sdat_q        <= 1'b1;
            nbits         <= '0;
            shift         <= '0;
            refuse_left   <= '0;
            ack_q         <= 1'b0;
            o_start       <= 1'b0;
            o_frame_valid <= 1'b0;
            o_frame       <= '0;
        end else begin
            sclk_q        <= i_sclk;
            sdat_q        <= i_sdat;
            o_start       <= 1'b0;
            o_frame_valid <= 1'b0;
            if (i_refuse_set) begin
                refuse_left <= i_refuse_cnt;
            end
            if (sclk_q && i_sclk && sdat_q && !i_sdat) begin
                nbits   <= '0;   // start condition
                o_start <= 1'b1;
            end else if (sclk_q && i_sclk && !sdat_q && i_sdat) begin
                if (nbits == 5'd24) begin
                    o_frame_valid <= 1'b1;
                    o_frame       <= shift;
                end
                nbits <= '0;
            end else if (!sclk_q && i_sclk && i_oen && (nbits != 5'd24)) begin
                shift <= {shift[22:0], i_sdat};
                nbits <= nbits + 5'd1;
                // decide the ack for the byte that ends with this bit
                if (nbits[2:0] == 3'd7) begin
                    if ((nbits == 5'd7) && (refuse_left != 0)) begin
                        ack_q       <= 1'b1;
                        refuse_left <= refuse_left - 2'd1;
                    end else begin
                        ack_q <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

// File: hdl/codec_cfg_top.sv
`timescale 1ns/10ps

module codec_cfg_top (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_start,
    input  logic       i_wr_valid,
    input  logic [6:0] i_wr_addr,
    input  logic [8:0] i_wr_data,
    input  logic       i_ack,
    output logic       o_wr_ready,
    output logic       o_init_done,
    output logic       o_nack_err,
    output logic       o_sclk,
    output logic       o_sdat,
    output logic       o_oen
);

    cmd_link_if init_link ();
    cmd_link_if host_link ();
    cmd_link_if eng_link ();

    init_sequencer u_init_seq (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_start (i_start),
        .link    (init_link)
    );

    host_write_queue u_host_queue (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_wr_valid (i_wr_valid),
        .i_wr_addr  (i_wr_addr),
        .i_wr_data  (i_wr_data),
        .o_wr_ready (o_wr_ready),
        .link       (host_link)
    );

    cmd_arbiter u_arbiter (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .init_link (init_link),
        .host_link (host_link),
        .eng_link  (eng_link)
    );

    i2c_write_engine u_engine (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_ack       (i_ack),
        .o_sclk      (o_sclk),
        .o_sdat      (o_sdat),
        .o_oen       (o_oen),
        .o_init_done (o_init_done),
        .o_nack_err  (o_nack_err),
        .link        (eng_link)
    );

endmodule

// File: hdl/i2c_write_engine.sv
`timescale 1ns/10ps

module i2c_write_engine (
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_ack,
    output logic     o_sclk,
    output logic     o_sdat,
    output logic     o_oen,
    output logic     o_init_done,
    output logic     o_nack_err,
    cmd_link_if.sink link
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_START,
        S_DATA,
        S_ACK,
        S_STOP
    } state_t;

    state_t                                           state;
    logic [24:0]                                      buf_mem [codec_cfg_pkg::ENG_CREDITS];
    logic [$clog2(codec_cfg_pkg::ENG_CREDITS) - 1:0]  buf_wr_ptr;
    logic [$clog2(codec_cfg_pkg::ENG_CREDITS) - 1:0]  buf_rd_ptr;
    logic [$clog2(codec_cfg_pkg::ENG_CREDITS + 1) - 1:0] buf_count;
    logic                                             pop;
    codec_cfg_pkg::frame_t                            cur_frame;
    logic                                             cur_last;
    logic [4:0]                                       bit_idx;   // bit now on the bus
    logic [4:0]                                       nxt_idx;
    logic [$clog2(codec_cfg_pkg::MAX_RETRIES) - 1:0]  attempt;
    logic                                             nacked;

    assign pop     = (state == S_IDLE) && (buf_count != 0);
    assign nxt_idx = bit_idx - 5'd1;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state       <= S_IDLE;
            o_sclk      <= 1'b1;
            o_sdat      <= 1'b1;
            o_oen       <= 1'b1;
            o_init_done <= 1'b0;
            o_nack_err  <= 1'b0;
            bit_idx     <= '0;
            attempt     <= '0;
            nacked      <= 1'b0;
            buf_wr_ptr  <= '0;
            buf_rd_ptr  <= '0;
            buf_count   <= '0;
            link.credit <= 1'b0;
        end else begin
            o_nack_err  <= 1'b0;
            link.credit <= pop;   // credit back on pop, not on completion
            buf_count   <= buf_count + link.valid - pop;
            if (link.valid) begin
                buf_wr_ptr <= buf_wr_ptr + 1'b1;
            end
            if (pop) begin
                buf_rd_ptr <= buf_rd_ptr + 1'b1;
            end
            case (state)
                S_IDLE: begin
                    if (pop) begin
                        attempt <= '0;
                        state   <= S_START;
                    end
                end
                S_START: begin
                    if (o_sdat) begin
                        o_sdat <= 1'b0;   // sda falls while scl high
                    end else begin
                        o_sclk  <= 1'b0;
                        o_sdat  <= cur_frame[23];
                        bit_idx <= 5'd23;
                        nacked  <= 1'b0;
                        state   <= S_DATA;
                    end
                end
                S_DATA: begin
                    o_sclk <= ~o_sclk;
                    if (o_sclk) begin
                        if (bit_idx[2:0] == 3'd0) begin
                            o_oen <= 1'b0;   // release sda for ack
                            state <= S_ACK;
                        end else begin
                            o_sdat  <= cur_frame[nxt_idx];
                            bit_idx <= nxt_idx;
                        end
                    end
                end
                S_ACK: begin
                    o_sclk <= ~o_sclk;
                    if (o_sclk) begin
                        o_oen <= 1'b1;
                        if (i_ack) begin
                            nacked <= 1'b1;
                            o_sdat <= 1'b0;
                            state  <= S_STOP;
                        end else if (bit_idx == 5'd0) begin
                            o_sdat <= 1'b0;
                            state  <= S_STOP;
                        end else begin
                            o_sdat  <= cur_frame[nxt_idx];
                            bit_idx <= nxt_idx;
                            state   <= S_DATA;
                        end
                    end
                end
                S_STOP: begin
                    if (!o_sclk) begin
                        o_sclk <= 1'b1;
                    end else if (!o_sdat) begin
                        o_sdat <= 1'b1;   // stop condition
                    end else if (nacked && (attempt != codec_cfg_pkg::MAX_RETRIES - 1)) begin
                        attempt <= attempt + 1'b1;
                        state   <= S_START;
                    end else begin
                        o_nack_err <= nacked;   // dropped after last attempt
                        if (cur_last) begin
                            o_init_done <= 1'b1;
                        end
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (link.valid) begin
            buf_mem[buf_wr_ptr] <= {link.last, link.frame};
        end
        if (pop) begin
            {cur_last, cur_frame} <= buf_mem[buf_rd_ptr];
        end
    end

endmodule

// File: hdl/cmd_arbiter.sv
`timescale 1ns/10ps

module cmd_arbiter (
    input  logic       i_clk,
    input  logic       i_rst_n,
    cmd_link_if.sink   init_link,
    cmd_link_if.sink   host_link,
    cmd_link_if.source eng_link
);

    typedef logic [$clog2(codec_cfg_pkg::ENG_CREDITS + 1) - 1:0] cred_t;

    codec_cfg_pkg::frame_t init_hold;
    codec_cfg_pkg::frame_t host_hold;
    logic                  init_hold_v;
    logic                  host_hold_v;
    logic                  init_hold_last;
    logic                  host_hold_last;
    cred_t                 eng_credits;
    logic                  eng_avail;
    logic                  grant_init;
    logic                  grant_host;

    assign eng_avail  = (eng_credits != 0) || eng_link.credit;
    assign grant_init = init_hold_v && eng_avail;                   // init wins
    assign grant_host = host_hold_v && !init_hold_v && eng_avail;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            init_hold_v      <= 1'b0;
            host_hold_v      <= 1'b0;
            eng_credits      <= cred_t'(codec_cfg_pkg::ENG_CREDITS);
            eng_link.valid   <= 1'b0;
            init_link.credit <= 1'b0;
            host_link.credit <= 1'b0;
        end else begin
            eng_credits      <= eng_credits + eng_link.credit - (grant_init || grant_host);
            eng_link.valid   <= grant_init || grant_host;
            init_link.credit <= grant_init;   // slot freed as the frame leaves
            host_link.credit <= grant_host;
            if (init_link.valid) begin
                init_hold_v <= 1'b1;
            end else if (grant_init) begin
                init_hold_v <= 1'b0;
            end
            if (host_link.valid) begin
                host_hold_v <= 1'b1;
            end else if (grant_host) begin
                host_hold_v <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (init_link.valid) begin
            init_hold      <= init_link.frame;
            init_hold_last <= init_link.last;
        end
        if (host_link.valid) begin
            host_hold      <= host_link.frame;
            host_hold_last <= host_link.last;
        end
        if (grant_init) begin
            eng_link.frame <= init_hold;
            eng_link.last  <= init_hold_last;
        end else if (grant_host) begin
            eng_link.frame <= host_hold;
            eng_link.last  <= host_hold_last;
        end
    end

endmodule

// File: hdl/host_write_queue.sv
`timescale 1ns/10ps

module host_write_queue (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_wr_valid,
    input  logic [6:0] i_wr_addr,
    input  logic [8:0] i_wr_data,
    output logic       o_wr_ready,
    cmd_link_if.source link
);

    typedef logic [$clog2(codec_cfg_pkg::SRC_CREDITS + 1) - 1:0] cred_t;

    logic [15:0]                                     fifo_mem [codec_cfg_pkg::QUEUE_DEPTH];
    logic [$clog2(codec_cfg_pkg::QUEUE_DEPTH) - 1:0] wr_ptr;
    logic [$clog2(codec_cfg_pkg::QUEUE_DEPTH) - 1:0] rd_ptr;
    logic [$clog2(codec_cfg_pkg::QUEUE_DEPTH + 1) - 1:0] count;
    logic [$clog2(codec_cfg_pkg::QUEUE_DEPTH + 1) - 1:0] count_nxt;
    cred_t                                           credits;
    logic                                            push;
    logic                                            send;

    assign push      = i_wr_valid && o_wr_ready;
    assign send      = (count != 0) && ((credits != 0) || link.credit);
    assign count_nxt = count + push - send;

    assign link.last = 1'b0;   // host writes never end a burst

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credits    <= cred_t'(codec_cfg_pkg::SRC_CREDITS);
            o_wr_ready <= 1'b0;
            link.valid <= 1'b0;
        end else begin
            count      <= count_nxt;
            credits    <= credits + link.credit - send;
            o_wr_ready <= (count_nxt != codec_cfg_pkg::QUEUE_DEPTH);
            link.valid <= send;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (send) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // entry is {addr, data}, which is already the low 16 bits of a frame
    always_ff @(posedge i_clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= {i_wr_addr, i_wr_data};
        end
        if (send) begin
            link.frame <= {codec_cfg_pkg::DEV_ADDR, fifo_mem[rd_ptr]};
        end
    end

endmodule

// File: hdl/init_sequencer.sv
`timescale 1ns/10ps

module init_sequencer (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_start,
    cmd_link_if.source link
);

    typedef logic [$clog2(codec_cfg_pkg::SRC_CREDITS + 1) - 1:0] cred_t;

    logic [$clog2(codec_cfg_pkg::INIT_LEN) - 1:0] idx;
    cred_t                                        credits;
    logic                                         running;
    logic                                         send;
    logic                                         at_end;

    // a returning credit can be spent in the same cycle
    assign send   = running && ((credits != 0) || link.credit);
    assign at_end = (idx == codec_cfg_pkg::INIT_LEN - 1);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            running    <= 1'b0;
            idx        <= '0;
            credits    <= cred_t'(codec_cfg_pkg::SRC_CREDITS);
            link.valid <= 1'b0;
            link.last  <= 1'b0;
        end else begin
            credits    <= credits + link.credit - send;
            link.valid <= send;
            link.last  <= send && at_end;
            if (i_start && !running) begin
                running <= 1'b1;
                idx     <= '0;
            end else if (send) begin
                if (at_end) begin
                    running <= 1'b0;   // table finished
                end else begin
                    idx <= idx + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (send) begin
            link.frame <= codec_cfg_pkg::INIT_TABLE[idx];
        end
    end

endmodule

// File: hdl/cmd_link_if.sv
`timescale 1ns/10ps

interface cmd_link_if;

    logic                  valid;
    codec_cfg_pkg::frame_t frame;
    logic                  credit;   // one pulse per freed slot
    logic                  last;     // end of burst

    modport source (
        output valid,
        output frame,
        output last,
        input  credit
    );

    modport sink (
        input  valid,
        input  frame,
        input  last,
        output credit
    );

endinterface

// File: hdl/codec_cfg_pkg.sv
package codec_cfg_pkg;

    // {device byte, reg addr[6:0] + data[8], data[7:0]}
    typedef logic [23:0] frame_t;

    localparam logic [7:0] DEV_ADDR = 8'h34;

    localparam int INIT_LEN = 7;

    // power-up sequence, sent in order
    localparam frame_t INIT_TABLE [INIT_LEN] = '{
        24'h34_1E_00,   // reset
        24'h34_01_17,   // line in volume, both channels
        24'h34_05_79,   // headphone volume, both channels
        24'h34_08_15,   // analog path
        24'h34_0A_00,   // digital path
        24'h34_0C_00,   // power down off
        24'h34_12_01    // active
    };

    localparam int SRC_CREDITS = 1;   // source to arbiter
    localparam int ENG_CREDITS = 2;   // arbiter to engine, engine buffer depth

    localparam int MAX_RETRIES = 3;

    localparam int QUEUE_DEPTH = 4;

endpackage
